// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module rvCoreTb -f build.f -o rvCoreTb

run: compile
	./obj_dir/rvCoreTb | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
source/rvPkg.sv
source/regFile.sv
source/instrDecoder.sv
source/aluExecute.sv
source/resultWriteback.sv
source/rvCoreTop.sv
sim/rvCoreTb.sv

// ==== sim/rvCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    localparam int NumInstr = 400;
    localparam int ResetCycles = 16;
    localparam int TimeoutCycles = NumInstr * 2 + 100;

    logic clk;
    logic rst;
    logic instrValid;
    Instruction instr;
    logic wbValid;
    RegAddr wbRd;
    Word wbData;
    logic illegalInstr;

    integer seed = 32'h3f18_e754;
    logic [31:0] modelRegs [32];
    logic [1:0] expKind [$]; // 0 no pulse, 1 writeback, 2 illegal
    logic [4:0] expRd [$];
    logic [31:0] expData [$];

    rvCoreTop #(.regCount(32)) u_rvCoreTop (
        .clk, .rst, .instrValid, .instr,
        .wbValid, .wbRd, .wbData, .illegalInstr
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int randRange(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // Small pool keeps dependencies close together
    function automatic logic [4:0] pickReg();
        return 5'(randRange(6));
    endfunction

    // RV32I arithmetic as the ISA defines it
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic modelExecute(input logic [31:0] word, output logic [1:0] kind,
                                output logic [4:0] rd, output logic [31:0] data);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] a;
        logic [31:0] b;
        logic legal;
        f3 = word[14:12];
        f7 = word[31:25];
        rd = word[11:7];
        a = modelRegs[word[19:15]];
        legal = 1'b1;
        data = '0;
        case (word[6:0])
            7'b0110011: // OP
            begin
                b = modelRegs[word[24:20]];
                legal = f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5));
                data = refAlu(f3, f7[5], a, b);
            end
            7'b0010011: // OP_IMM, no SUBI
            begin
                b = {{20{word[31]}}, word[31:20]};
                if (f3 == 3'd1 && f7 != 7'b0)
                    legal = 1'b0;
                if (f3 == 3'd5 && f7 != 7'b0 && f7 != 7'b0100000)
                    legal = 1'b0;
                data = refAlu(f3, f3 == 3'd5 && f7[5], a, b);
            end
            7'b0110111: data = {word[31:12], 12'b0}; // LUI
            default: legal = 1'b0;
        endcase
        if (!legal)
            kind = 2'd2;
        else if (rd == 5'd0)
            kind = 2'd0;
        else
        begin
            kind = 2'd1;
            modelRegs[rd] = data;
        end
    endtask

    task automatic genInstr(output logic [31:0] word);
        int cls;
        logic [31:0] rnd;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] opField;
        cls = randRange(100);
        rnd = $random(seed);
        rd = pickReg();
        rs1 = pickReg();
        rs2 = pickReg();
        f3 = rnd[14:12];
        f7 = 7'b0;
        if (cls < 40)
        begin
            if ((f3 == 3'd0 || f3 == 3'd5) && rnd[30])
                f7 = 7'b0100000; // SUB or SRA
            word = {f7, rs2, rs1, f3, rd, 7'b0110011};
        end
        else if (cls < 70)
        begin
            f7 = rnd[31:25];
            if (f3 == 3'd1)
                f7 = 7'b0;
            else if (f3 == 3'd5)
                f7 = rnd[30] ? 7'b0100000 : 7'b0;
            word = {f7, rnd[24:20], rs1, f3, rd, 7'b0010011};
        end
        else if (cls < 78)
            word = {rnd[31:12], rd, 7'b0110111};
        else if (cls < 84)
        begin
            opField = rnd[6:2];
            while (opField == 5'b01100 || opField == 5'b00100 || opField == 5'b01101)
            begin
                rnd = $random(seed);
                opField = rnd[6:2];
            end
            word = {rnd[31:7], opField, 2'b11};
        end
        else if (cls < 89)
            word = {f7, rs2, rs1, f3, rd, 5'b01100, 2'(randRange(3))}; // Low bits not 11
        else if (cls < 94)
            word = {rnd[31:25] | 7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
        else
        begin
            f3 = rnd[0] ? 3'd5 : 3'd1; // SRLI or SLLI with a bad funct7
            word = {rnd[31:25] | 7'b0000010, rnd[24:20], rs1, f3, rd, 7'b0010011};
        end
    endtask

    // Checks the entry issued three cycles ago, then issues the next one
    task automatic stepCycle(input logic valid, input logic [31:0] word);
        logic [1:0] kind;
        logic [4:0] rd;
        logic [31:0] data;
        @(posedge clk);
        #2;
        kind = expKind.pop_front();
        rd = expRd.pop_front();
        data = expData.pop_front();
        checkValue("wbValid", 32'(wbValid), 32'(kind == 2'd1));
        checkValue("illegalInstr", 32'(illegalInstr), 32'(kind == 2'd2));
        if (kind == 2'd1)
        begin
            checkValue("wbRd", 32'(wbRd), 32'(rd));
            checkValue("wbData", wbData, data);
        end
        instrValid = valid;
        instr = word; // Junk while invalid
        kind = 2'd0;
        rd = '0;
        data = '0;
        if (valid)
            modelExecute(word, kind, rd, data);
        expKind.push_back(kind);
        expRd.push_back(rd);
        expData.push_back(data);
    endtask

    initial
    begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Watchdog expired before all instructions were checked");
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    initial
    begin
        logic [31:0] word;
        int issued;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        issued = 0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        repeat (3)
        begin
            expKind.push_back(2'd0);
            expRd.push_back(5'd0);
            expData.push_back(32'd0);
        end
        repeat (ResetCycles) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (10) stepCycle(1'b0, 32'h0); // Idle after reset, no pulses
        while (issued < NumInstr)
        begin
            word = $random(seed);
            if (randRange(5) == 0)
                stepCycle(1'b0, word);
            else
            begin
                genInstr(word);
                stepCycle(1'b1, word);
                issued++;
            end
        end
        repeat (3) stepCycle(1'b0, 32'h0); // Drain the pipeline
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/aluExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExecute
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       decValid,
    input  rvPkg::AluOp     decAluOp,
    input  rvPkg::Word      decOperandA,
    input  rvPkg::Word      decOperandB,
    input  rvPkg::RegAddr   decRs1,
    input  rvPkg::RegAddr   decRs2,
    input  wire logic       decUsesRs2,
    input  rvPkg::RegAddr   decRd,
    input  wire logic       decIllegal,
    input  wire logic       regWe,
    input  rvPkg::RegAddr   regWAddr,
    input  rvPkg::Word      regWData,
    output logic            exValid,
    output rvPkg::RegAddr   exRd,
    output rvPkg::Word      exResult,
    output logic            exWrites,
    output logic            exIllegal
);
    import rvPkg::*;

    Word opA;
    Word opB;
    Word aluResult;
    logic [4:0] shamt;

    // Youngest producer wins: own output first, then the result stage
    always_comb
    begin
        opA = decOperandA;
        if (exWrites && exRd == decRs1)
            opA = exResult;
        else if (regWe && regWAddr == decRs1)
            opA = regWData;

        opB = decOperandB;
        if (decUsesRs2)
        begin
            if (exWrites && exRd == decRs2)
                opB = exResult;
            else if (regWe && regWAddr == decRs2)
                opB = regWData;
        end
    end

    assign shamt = opB[4:0];

    always_comb
    begin
        case (decAluOp)
            ALU_ADD:   aluResult = opA + opB;
            ALU_SUB:   aluResult = opA - opB;
            ALU_SLL:   aluResult = opA << shamt;
            ALU_SLT:   aluResult = {{(Xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluResult = {{(Xlen-1){1'b0}}, opA < opB};
            ALU_XOR:   aluResult = opA ^ opB;
            ALU_SRL:   aluResult = opA >> shamt;
            ALU_SRA:   aluResult = Word'($signed(opA) >>> shamt);
            ALU_OR:    aluResult = opA | opB;
            ALU_AND:   aluResult = opA & opB;
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exValid   <= 1'b0;
            exWrites  <= 1'b0;
            exIllegal <= 1'b0;
        end
        else
        begin
            exValid   <= decValid;
            exWrites  <= decValid && !decIllegal && decRd != '0; // Also gates forwarding
            exIllegal <= decValid && decIllegal;
        end
    end

    always_ff @(posedge clk)
    begin
        if (decValid)
        begin
            exRd     <= decRd;
            exResult <= aluResult;
        end
    end

endmodule

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
#(
    parameter int regCount = 32
)
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            instrValid,
    input  rvPkg::Instruction    instr,
    input  rvPkg::Word           rs1Data,
    input  rvPkg::Word           rs2Data,
    output rvPkg::RegAddr        rs1Addr,
    output rvPkg::RegAddr        rs2Addr,
    output logic                 decValid,
    output rvPkg::AluOp          decAluOp,
    output rvPkg::Word           decOperandA,
    output rvPkg::Word           decOperandB,
    output rvPkg::RegAddr        decRs1,
    output rvPkg::RegAddr        decRs2,
    output logic                 decUsesRs2,
    output rvPkg::RegAddr        decRd,
    output logic                 decIllegal
);
    import rvPkg::*;

    Funct3Op f3;
    Word immI;
    Word immU;
    Word operandB;
    AluOp aluOp;
    logic usesRs1;
    logic usesRs2;
    logic knownOp;
    logic badFunct7;
    logic badReg;
    logic isAlt;
    logic isZero;
    logic illegal;

    function automatic AluOp mapFunct3(Funct3Op code, logic alt);
        case (code)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SRLA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1Addr = instr.rs1;
    assign rs2Addr = instr.rs2;

    assign f3     = Funct3Op'(instr.funct3);
    assign isAlt  = instr.funct7 == 7'b0100000;
    assign isZero = instr.funct7 == 7'b0000000;
    assign immI   = {{(Xlen-12){instr.funct7[6]}}, instr.funct7, instr.rs2}; // Sign-extended
    assign immU   = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'b0};

    always_comb
    begin
        aluOp     = ALU_ADD;
        operandB  = immI;
        usesRs1   = 1'b0;
        usesRs2   = 1'b0;
        knownOp   = 1'b1;
        badFunct7 = 1'b0;
        case (instr.opCode)
            OP:
            begin
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                operandB  = rs2Data;
                aluOp     = mapFunct3(f3, isAlt);
                badFunct7 = !(isZero || (isAlt && (f3 == F3_ADD || f3 == F3_SRLA)));
            end
            OP_IMM:
            begin
                usesRs1 = 1'b1;
                aluOp   = mapFunct3(f3, isAlt && f3 == F3_SRLA); // No SUBI
                // Upper immediate bits act as funct7 only for shifts
                if (f3 == F3_SLL || f3 == F3_SRLA)
                    badFunct7 = !(isZero || (isAlt && f3 == F3_SRLA));
            end
            LUI:
            begin
                aluOp    = ALU_PASSB;
                operandB = immU;
            end
            default: knownOp = 1'b0;
        endcase
    end

    assign badReg = int'(instr.rd) >= regCount
                    || (usesRs1 && int'(instr.rs1) >= regCount)
                    || (usesRs2 && int'(instr.rs2) >= regCount);

    assign illegal = instr.lowBits != 2'b11 || !knownOp || badFunct7 || badReg;

    always_ff @(posedge clk)
    begin
        if (rst)
            decValid <= 1'b0;
        else
            decValid <= instrValid;
    end

    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            decAluOp    <= aluOp;
            decOperandA <= usesRs1 ? rs1Data : '0;
            decOperandB <= operandB;
            decRs1      <= usesRs1 ? instr.rs1 : '0; // x0 never matches a forward
            decRs2      <= instr.rs2;
            decUsesRs2  <= usesRs2;
            decRd       <= instr.rd;
            decIllegal  <= illegal;
        end
    end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile
#(
    parameter int regCount = 32
)
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  rvPkg::RegAddr   rs1Addr,
    input  rvPkg::RegAddr   rs2Addr,
    input  wire logic       regWe,
    input  rvPkg::RegAddr   regWAddr,
    input  rvPkg::Word      regWData,
    output rvPkg::Word      rs1Data,
    output rvPkg::Word      rs2Data
);
    import rvPkg::*;

    Word regs [regCount];

    // Write-through so a read in the write cycle sees the new value
    function automatic Word readReg(RegAddr addr);
        if (addr == '0 || int'(addr) >= regCount)
            return '0;
        if (regWe && regWAddr == addr)
            return regWData;
        return regs[addr];
    endfunction

    always_comb
    begin
        rs1Data = readReg(rs1Addr);
        rs2Data = readReg(rs2Addr);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (regWe && regWAddr != '0 && int'(regWAddr) < regCount)
            regs[regWAddr] <= regWData;
    end

endmodule

`default_nettype wire

// ==== source/resultWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultWriteback
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       exValid,
    input  rvPkg::RegAddr   exRd,
    input  rvPkg::Word      exResult,
    input  wire logic       exWrites,
    input  wire logic       exIllegal,
    output logic            regWe,
    output rvPkg::RegAddr   regWAddr,
    output rvPkg::Word      regWData,
    output logic            illegalInstr
);

    // Pulses are single-cycle since exValid is
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            regWe        <= 1'b0;
            illegalInstr <= 1'b0;
        end
        else
        begin
            regWe        <= exValid && exWrites;
            illegalInstr <= exValid && exIllegal;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exValid)
        begin
            regWAddr <= exRd;
            regWData <= exResult;
        end
    end

endmodule

`default_nettype wire

// ==== source/rvCoreTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCoreTop
#(
    parameter int regCount = 32 // 16 for an RV32E register set
)
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           instrValid,
    input  rvPkg::Instruction   instr,
    output logic                wbValid,
    output rvPkg::RegAddr       wbRd,
    output rvPkg::Word          wbData,
    output logic                illegalInstr
);
    import rvPkg::*;

    RegAddr rs1Addr;
    RegAddr rs2Addr;
    Word rs1Data;
    Word rs2Data;

    logic decValid;
    AluOp decAluOp;
    Word decOperandA;
    Word decOperandB;
    RegAddr decRs1;
    RegAddr decRs2;
    logic decUsesRs2;
    RegAddr decRd;
    logic decIllegal;

    logic exValid;
    RegAddr exRd;
    Word exResult;
    logic exWrites;
    logic exIllegal;

    instrDecoder #(.regCount(regCount)) u_instrDecoder (
        .clk, .rst, .instrValid, .instr,
        .rs1Data, .rs2Data, .rs1Addr, .rs2Addr,
        .decValid, .decAluOp, .decOperandA, .decOperandB,
        .decRs1, .decRs2, .decUsesRs2, .decRd, .decIllegal
    );

    // Write port is fed by the observable writeback
    regFile #(.regCount(regCount)) u_regFile (
        .clk, .rst, .rs1Addr, .rs2Addr,
        .regWe(wbValid), .regWAddr(wbRd), .regWData(wbData),
        .rs1Data, .rs2Data
    );

    aluExecute u_aluExecute (
        .clk, .rst,
        .decValid, .decAluOp, .decOperandA, .decOperandB,
        .decRs1, .decRs2, .decUsesRs2, .decRd, .decIllegal,
        .regWe(wbValid), .regWAddr(wbRd), .regWData(wbData),
        .exValid, .exRd, .exResult, .exWrites, .exIllegal
    );

    resultWriteback u_resultWriteback (
        .clk, .rst,
        .exValid, .exRd, .exResult, .exWrites, .exIllegal,
        .regWe(wbValid), .regWAddr(wbRd), .regWData(wbData),
        .illegalInstr
    );

endmodule

`default_nettype wire

// ==== source/rvPkg.sv ====
`default_nettype none

package rvPkg;

    localparam int Xlen = 32; // Fixed to RV32 encodings

    typedef logic [Xlen-1:0] Word;
    typedef logic [4:0] RegAddr;

    // Major opcode, taken from instruction bits 6:2
    typedef enum logic [4:0]
    {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100, // Register-immediate arithmetic
        OP     = 5'b01100, // Register-register arithmetic
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } OpCode;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB // Operand B straight through for LUI
    } AluOp;

    typedef enum logic [2:0]
    {
        F3_ADD  = 3'b000, // ADD or SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRLA = 3'b101, // SRL or SRA, picked by funct7
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } Funct3Op;

    // Field view of a 32-bit instruction, R-type layout
    typedef struct packed
    {
        logic [6:0] funct7;
        RegAddr rs2;
        RegAddr rs1;
        logic [2:0] funct3;
        RegAddr rd;
        OpCode opCode;
        logic [1:0] lowBits; // Must be 2'b11 for 32-bit encodings
    } Instruction;

endpackage

`default_nettype wire
